// ==== include/graph_defines.svh ====
`ifndef GRAPH_DEFINES_SVH
`define GRAPH_DEFINES_SVH

// node IDs and table capacity
`define GRAPH_NODE_BITS 6
`define GRAPH_MAX_NODES 64

// compressed-row edge storage
`define GRAPH_EDGE_BITS 8
`define GRAPH_MAX_EDGES 256
`define GRAPH_DEGREE_BITS 5

`define GRAPH_STACK_DEPTH 32
`define GRAPH_COUNT_BITS 64
`define GRAPH_ROM_ADDR_BITS 12

`endif

// ==== source/graph_pkg.sv ====
package graph_pkg;

    // three ASCII letters with the first one in the top byte
    typedef logic [23:0] node_name_t;

    typedef enum logic [2:0] {
        PARSE_CLEAR_WAIT,
        PARSE_FETCH,
        PARSE_LOOKUP,
        PARSE_DECIDE,
        PARSE_FINISHED
    } parse_state_t;

    typedef enum logic [2:0] {
        COUNT_IDLE,
        COUNT_START_NODE,
        COUNT_FETCH_HEAD,
        COUNT_HEAD_READY,
        COUNT_ITERATE,
        COUNT_FETCH_EDGE,
        COUNT_PROCESS_EDGE
    } count_state_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOOKUP_SRC,
        SEQ_LOOKUP_DST,
        SEQ_COUNT,
        SEQ_RESPOND
    } seq_state_t;

endpackage

// ==== source/graph_if.sv ====
`timescale 1ns/1ps
`include "graph_defines.svh"

// name to node ID lookup
// the client holds name and req_valid until id_valid pulses
interface name_if;
    graph_pkg::node_name_t name;
    logic req_valid;
    logic [`GRAPH_NODE_BITS-1:0] id;
    logic id_valid;

    modport client (output name, output req_valid, input id, input id_valid);
    modport server (input name, input req_valid, output id, output id_valid);
endinterface

// adjacency reads, data registered one cycle after the address
interface adj_if;
    logic [`GRAPH_NODE_BITS-1:0] node_addr;
    logic [`GRAPH_EDGE_BITS-1:0] head_start;
    logic [`GRAPH_DEGREE_BITS-1:0] head_count;
    logic [`GRAPH_EDGE_BITS-1:0] edge_addr;
    logic [`GRAPH_NODE_BITS-1:0] edge_to;

    modport reader (
        output node_addr, edge_addr,
        input head_start, head_count, edge_to
    );
    modport store (
        input node_addr, edge_addr,
        output head_start, head_count, edge_to
    );
endinterface

// ==== source/name_table.sv ====
`timescale 1ns/1ps
`include "graph_defines.svh"

module name_table (
    input logic clk,
    input logic rst,
    name_if.server parser_port,
    name_if.server query_port
);

    graph_pkg::node_name_t names [0:`GRAPH_MAX_NODES-1];
    graph_pkg::node_name_t key;
    logic [`GRAPH_NODE_BITS:0] node_count;
    logic [`GRAPH_NODE_BITS:0] search_idx;
    logic [`GRAPH_NODE_BITS-1:0] id;
    logic busy;
    logic grant_query;
    logic parser_done;
    logic query_done;
    logic insert;

    assign key = grant_query ? query_port.name : parser_port.name;
    // scanned past every stored name without a hit
    assign insert = busy && (search_idx == node_count);

    assign parser_port.id = id;
    assign query_port.id = id;
    assign parser_port.id_valid = parser_done;
    assign query_port.id_valid = query_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            node_count <= '0;
            busy <= 1'b0;
            grant_query <= 1'b0;
            parser_done <= 1'b0;
            query_done <= 1'b0;
        end else begin
            parser_done <= 1'b0;
            query_done <= 1'b0;
            // a client still sees its id_valid this cycle, so its request is stale
            if (!busy) begin
                if (!parser_done && !query_done &&
                    (parser_port.req_valid || query_port.req_valid)) begin
                    busy <= 1'b1;
                    grant_query <= !parser_port.req_valid;
                    search_idx <= '0;
                end
            end else if (insert) begin
                names[node_count[`GRAPH_NODE_BITS-1:0]] <= key;
                id <= node_count[`GRAPH_NODE_BITS-1:0];
                node_count <= node_count + 1'b1;
                busy <= 1'b0;
                parser_done <= !grant_query;
                query_done <= grant_query;
            end else if (names[search_idx[`GRAPH_NODE_BITS-1:0]] == key) begin
                id <= search_idx[`GRAPH_NODE_BITS-1:0];
                busy <= 1'b0;
                parser_done <= !grant_query;
                query_done <= grant_query;
            end else begin
                search_idx <= search_idx + 1'b1;
            end
        end
    end

    table_not_full: assert property (
        @(posedge clk) disable iff (rst) insert |-> node_count < `GRAPH_MAX_NODES
    );

endmodule

// ==== source/adjacency_store.sv ====
`timescale 1ns/1ps
`include "graph_defines.svh"

module adjacency_store (
    input logic clk,
    input logic rst,
    input logic edge_valid,
    input logic [`GRAPH_NODE_BITS-1:0] edge_src,
    input logic [`GRAPH_NODE_BITS-1:0] edge_dst,
    output logic store_ready,
    adj_if.store rd
);

    logic [`GRAPH_EDGE_BITS-1:0] heads [0:`GRAPH_MAX_NODES-1];
    logic [`GRAPH_DEGREE_BITS-1:0] counts [0:`GRAPH_MAX_NODES-1];
    logic [`GRAPH_NODE_BITS-1:0] edges [0:`GRAPH_MAX_EDGES-1];
    logic [`GRAPH_EDGE_BITS:0] edge_count;
    logic [`GRAPH_NODE_BITS-1:0] clear_idx;

    // registered read ports
    always_ff @(posedge clk) begin
        rd.head_start <= heads[rd.node_addr];
        rd.head_count <= counts[rd.node_addr];
        rd.edge_to <= edges[rd.edge_addr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            edge_count <= '0;
            clear_idx <= '0;
            store_ready <= 1'b0;
        end else if (!store_ready) begin
            // one node cleared per cycle
            heads[clear_idx] <= '0;
            counts[clear_idx] <= '0;
            clear_idx <= clear_idx + 1'b1;
            if (clear_idx == `GRAPH_MAX_NODES - 1) begin
                store_ready <= 1'b1;
            end
        end else if (edge_valid) begin
            // edges of one source arrive back to back
            if (counts[edge_src] == '0) begin
                heads[edge_src] <= edge_count[`GRAPH_EDGE_BITS-1:0];
            end
            edges[edge_count[`GRAPH_EDGE_BITS-1:0]] <= edge_dst;
            counts[edge_src] <= counts[edge_src] + 1'b1;
            edge_count <= edge_count + 1'b1;
        end
    end

    edge_write_fits: assert property (
        @(posedge clk) disable iff (rst)
        edge_valid |-> store_ready && edge_count < `GRAPH_MAX_EDGES && counts[edge_src] != '1
    );

endmodule

// ==== source/netlist_parser.sv ====
`timescale 1ns/1ps
`include "graph_defines.svh"

module netlist_parser (
    input logic clk,
    input logic rst,
    output logic [`GRAPH_ROM_ADDR_BITS-1:0] rom_addr,
    input logic [7:0] rom_data,
    input logic rom_valid,
    input logic store_ready,
    name_if.client names,
    output logic edge_valid,
    output logic [`GRAPH_NODE_BITS-1:0] edge_src,
    output logic [`GRAPH_NODE_BITS-1:0] edge_dst,
    output logic graph_built
);

    graph_pkg::parse_state_t state;
    graph_pkg::node_name_t name_buf;
    logic [1:0] buf_count;
    logic has_src;
    logic [`GRAPH_NODE_BITS-1:0] cur_src;
    logic is_letter;

    assign is_letter = (rom_data >= "a") && (rom_data <= "z");
    assign names.name = name_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= graph_pkg::PARSE_CLEAR_WAIT;
            rom_addr <= '0;
            buf_count <= '0;
            has_src <= 1'b0;
            names.req_valid <= 1'b0;
            edge_valid <= 1'b0;
            graph_built <= 1'b0;
        end else begin
            edge_valid <= 1'b0;
            case (state)
                graph_pkg::PARSE_CLEAR_WAIT: begin
                    if (store_ready) begin
                        state <= graph_pkg::PARSE_FETCH;
                    end
                end
                graph_pkg::PARSE_FETCH: begin
                    if (!rom_valid || rom_data == 8'h00) begin
                        graph_built <= 1'b1;
                        state <= graph_pkg::PARSE_FINISHED;
                    end else begin
                        rom_addr <= rom_addr + 1'b1;
                        if (is_letter) begin
                            name_buf <= {name_buf[15:0], rom_data};
                            buf_count <= buf_count + 1'b1;
                            if (buf_count == 2'd2) begin
                                buf_count <= '0;
                                state <= graph_pkg::PARSE_LOOKUP;
                            end
                        end else if (rom_data == "\n") begin
                            has_src <= 1'b0;
                        end
                    end
                end
                graph_pkg::PARSE_LOOKUP: begin
                    names.req_valid <= 1'b1;
                    state <= graph_pkg::PARSE_DECIDE;
                end
                graph_pkg::PARSE_DECIDE: begin
                    if (names.id_valid) begin
                        names.req_valid <= 1'b0;
                        // first name of a line is the source
                        if (!has_src) begin
                            cur_src <= names.id;
                            has_src <= 1'b1;
                        end else begin
                            edge_src <= cur_src;
                            edge_dst <= names.id;
                            edge_valid <= 1'b1;
                        end
                        state <= graph_pkg::PARSE_FETCH;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== source/path_counter.sv ====
`timescale 1ns/1ps
`include "graph_defines.svh"

module path_counter (
    input logic clk,
    input logic rst,
    input logic count_start,
    input logic [`GRAPH_NODE_BITS-1:0] count_src,
    input logic [`GRAPH_NODE_BITS-1:0] count_dst,
    output logic count_done,
    output logic [`GRAPH_COUNT_BITS-1:0] count,
    adj_if.reader adj
);

    localparam int SP_BITS = $clog2(`GRAPH_STACK_DEPTH);

    graph_pkg::count_state_t state;

    // one stack frame per node on the current search path
    logic [`GRAPH_NODE_BITS-1:0] stk_node [0:`GRAPH_STACK_DEPTH-1];
    logic [`GRAPH_EDGE_BITS-1:0] stk_start [0:`GRAPH_STACK_DEPTH-1];
    logic [`GRAPH_DEGREE_BITS-1:0] stk_cnt [0:`GRAPH_STACK_DEPTH-1];
    logic [`GRAPH_DEGREE_BITS-1:0] stk_idx [0:`GRAPH_STACK_DEPTH-1];
    logic [`GRAPH_COUNT_BITS-1:0] stk_sum [0:`GRAPH_STACK_DEPTH-1];
    logic [SP_BITS:0] sp;
    logic [SP_BITS-1:0] top;
    logic [SP_BITS-1:0] parent;
    logic [SP_BITS-1:0] child;

    logic [`GRAPH_COUNT_BITS-1:0] memo [0:`GRAPH_MAX_NODES-1];
    logic [`GRAPH_MAX_NODES-1:0] memo_v;

    logic [`GRAPH_NODE_BITS-1:0] dst;
    logic [`GRAPH_NODE_BITS-1:0] cur_node;
    logic node_done;
    logic [`GRAPH_COUNT_BITS-1:0] done_val;

    assign top = sp[SP_BITS-1:0];
    assign parent = top - 1'b1;
    assign child = top + 1'b1;
    assign cur_node = stk_node[top];

    // the top frame finishes with done_val paths
    always_comb begin
        node_done = 1'b0;
        done_val = stk_sum[top];
        if (state == graph_pkg::COUNT_START_NODE) begin
            if (cur_node == dst) begin
                node_done = 1'b1;
                done_val = `GRAPH_COUNT_BITS'(1);
            end else if (memo_v[cur_node]) begin
                node_done = 1'b1;
                done_val = memo[cur_node];
            end
        end else if (state == graph_pkg::COUNT_ITERATE) begin
            node_done = (stk_idx[top] == stk_cnt[top]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= graph_pkg::COUNT_IDLE;
            count_done <= 1'b0;
            memo_v <= '0;
            sp <= '0;
        end else begin
            count_done <= 1'b0;
            if (node_done) begin
                if (state == graph_pkg::COUNT_ITERATE) begin
                    memo[cur_node] <= stk_sum[top];
                    memo_v[cur_node] <= 1'b1;
                end
                if (sp == '0) begin
                    count <= done_val;
                    count_done <= 1'b1;
                    state <= graph_pkg::COUNT_IDLE;
                end else begin
                    // return to the parent frame
                    stk_sum[parent] <= stk_sum[parent] + done_val;
                    sp <= sp - 1'b1;
                    state <= graph_pkg::COUNT_ITERATE;
                end
            end else begin
                case (state)
                    graph_pkg::COUNT_IDLE: begin
                        if (count_start) begin
                            memo_v <= '0;
                            sp <= '0;
                            stk_node[0] <= count_src;
                            stk_sum[0] <= '0;
                            dst <= count_dst;
                            state <= graph_pkg::COUNT_START_NODE;
                        end
                    end
                    graph_pkg::COUNT_START_NODE: begin
                        adj.node_addr <= cur_node;
                        state <= graph_pkg::COUNT_FETCH_HEAD;
                    end
                    graph_pkg::COUNT_FETCH_HEAD: begin
                        state <= graph_pkg::COUNT_HEAD_READY;
                    end
                    graph_pkg::COUNT_HEAD_READY: begin
                        stk_start[top] <= adj.head_start;
                        stk_cnt[top] <= adj.head_count;
                        stk_idx[top] <= '0;
                        state <= graph_pkg::COUNT_ITERATE;
                    end
                    graph_pkg::COUNT_ITERATE: begin
                        adj.edge_addr <= stk_start[top] + `GRAPH_EDGE_BITS'(stk_idx[top]);
                        stk_idx[top] <= stk_idx[top] + 1'b1;
                        state <= graph_pkg::COUNT_FETCH_EDGE;
                    end
                    graph_pkg::COUNT_FETCH_EDGE: begin
                        state <= graph_pkg::COUNT_PROCESS_EDGE;
                    end
                    graph_pkg::COUNT_PROCESS_EDGE: begin
                        // descend into the child
                        sp <= sp + 1'b1;
                        stk_node[child] <= adj.edge_to;
                        stk_sum[child] <= '0;
                        state <= graph_pkg::COUNT_START_NODE;
                    end
                    default: begin
                        state <= graph_pkg::COUNT_IDLE;
                    end
                endcase
            end
        end
    end

    stack_in_range: assert property (
        @(posedge clk) disable iff (rst) sp < `GRAPH_STACK_DEPTH
    );

endmodule

// ==== source/query_sequencer.sv ====
`timescale 1ns/1ps
`include "graph_defines.svh"

module query_sequencer (
    input logic clk,
    input logic rst,
    input logic graph_built,
    input logic query_valid,
    output logic query_ready,
    input graph_pkg::node_name_t query_src,
    input graph_pkg::node_name_t query_dst,
    name_if.client names,
    output logic count_start,
    output logic [`GRAPH_NODE_BITS-1:0] count_src,
    output logic [`GRAPH_NODE_BITS-1:0] count_dst,
    input logic count_done,
    input logic [`GRAPH_COUNT_BITS-1:0] count,
    output logic result_valid,
    input logic result_ready,
    output logic [`GRAPH_COUNT_BITS-1:0] result_count
);

    graph_pkg::seq_state_t state;
    graph_pkg::node_name_t src_name;
    graph_pkg::node_name_t dst_name;

    // one query in flight
    assign query_ready = graph_built && (state == graph_pkg::SEQ_IDLE);
    assign names.name = (state == graph_pkg::SEQ_LOOKUP_DST) ? dst_name : src_name;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= graph_pkg::SEQ_IDLE;
            names.req_valid <= 1'b0;
            count_start <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            count_start <= 1'b0;
            case (state)
                graph_pkg::SEQ_IDLE: begin
                    if (query_valid && query_ready) begin
                        src_name <= query_src;
                        dst_name <= query_dst;
                        names.req_valid <= 1'b1;
                        state <= graph_pkg::SEQ_LOOKUP_SRC;
                    end
                end
                graph_pkg::SEQ_LOOKUP_SRC: begin
                    // request stays up and the name switches to the destination
                    if (names.id_valid) begin
                        count_src <= names.id;
                        state <= graph_pkg::SEQ_LOOKUP_DST;
                    end
                end
                graph_pkg::SEQ_LOOKUP_DST: begin
                    if (names.id_valid) begin
                        count_dst <= names.id;
                        names.req_valid <= 1'b0;
                        count_start <= 1'b1;
                        state <= graph_pkg::SEQ_COUNT;
                    end
                end
                graph_pkg::SEQ_COUNT: begin
                    if (count_done) begin
                        result_count <= count;
                        result_valid <= 1'b1;
                        state <= graph_pkg::SEQ_RESPOND;
                    end
                end
                graph_pkg::SEQ_RESPOND: begin
                    if (result_ready) begin
                        result_valid <= 1'b0;
                        state <= graph_pkg::SEQ_IDLE;
                    end
                end
                default: begin
                    state <= graph_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/graph_solver.sv ====
`timescale 1ns/1ps
`include "graph_defines.svh"

module graph_solver (
    input logic clk,
    input logic rst,
    output logic [`GRAPH_ROM_ADDR_BITS-1:0] rom_addr,
    input logic [7:0] rom_data,
    input logic rom_valid,
    input logic query_valid,
    output logic query_ready,
    input graph_pkg::node_name_t query_src,
    input graph_pkg::node_name_t query_dst,
    output logic result_valid,
    input logic result_ready,
    output logic [`GRAPH_COUNT_BITS-1:0] result_count
);

    logic store_ready;
    logic edge_valid;
    logic [`GRAPH_NODE_BITS-1:0] edge_src;
    logic [`GRAPH_NODE_BITS-1:0] edge_dst;
    logic graph_built;
    logic count_start;
    logic [`GRAPH_NODE_BITS-1:0] count_src;
    logic [`GRAPH_NODE_BITS-1:0] count_dst;
    logic count_done;
    logic [`GRAPH_COUNT_BITS-1:0] count;

    name_if parser_names ();
    name_if query_names ();
    adj_if adj ();

    name_table name_table_i (
        .clk(clk),
        .rst(rst),
        .parser_port(parser_names),
        .query_port(query_names)
    );

    adjacency_store adjacency_store_i (
        .clk(clk),
        .rst(rst),
        .edge_valid(edge_valid),
        .edge_src(edge_src),
        .edge_dst(edge_dst),
        .store_ready(store_ready),
        .rd(adj)
    );

    netlist_parser netlist_parser_i (
        .clk(clk),
        .rst(rst),
        .rom_addr(rom_addr),
        .rom_data(rom_data),
        .rom_valid(rom_valid),
        .store_ready(store_ready),
        .names(parser_names),
        .edge_valid(edge_valid),
        .edge_src(edge_src),
        .edge_dst(edge_dst),
        .graph_built(graph_built)
    );

    path_counter path_counter_i (
        .clk(clk),
        .rst(rst),
        .count_start(count_start),
        .count_src(count_src),
        .count_dst(count_dst),
        .count_done(count_done),
        .count(count),
        .adj(adj)
    );

    query_sequencer query_sequencer_i (
        .clk(clk),
        .rst(rst),
        .graph_built(graph_built),
        .query_valid(query_valid),
        .query_ready(query_ready),
        .query_src(query_src),
        .query_dst(query_dst),
        .names(query_names),
        .count_start(count_start),
        .count_src(count_src),
        .count_dst(count_dst),
        .count_done(count_done),
        .count(count),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .result_count(result_count)
    );

endmodule

// ==== verification/netlist_rom.sv ====
`timescale 1ns/1ps
`include "graph_defines.svh"

module netlist_rom (
    input logic [`GRAPH_ROM_ADDR_BITS-1:0] addr,
    output logic [7:0] data,
    output logic valid
);

    logic [7:0] rom_bytes [0:127];
    string text;
    int text_len;

    initial begin
        text = "";
        text = {text, "you: aaa bbb\n"};
        text = {text, "aaa: ccc out\n"};
        text = {text, "bbb: ccc\n"};
        text = {text, "ccc: out ddd\n"};
        text = {text, "ddd: out\n"};
        text = {text, "svr: aaa\n"};
        text_len = text.len();
        for (int i = 0; i < text_len; i++) begin
            rom_bytes[i] = text[i];
        end
    end

    // the byte just past the text is the terminating zero and still valid
    assign valid = (int'(addr) <= text_len);
    assign data = (int'(addr) < text_len) ? rom_bytes[addr[6:0]] : 8'h00;

endmodule

// ==== verification/tb_graph_solver.sv ====
`timescale 1ns/1ps
`include "graph_defines.svh"

module tb_graph_solver;

    localparam int NUM_TESTS = 10;
    localparam int READY_TIMEOUT = 5000;
    localparam int RESULT_TIMEOUT = 2000;
    // address of the zero byte that ends the ROM text
    localparam int ROM_END = 66;

    logic clk;
    logic rst;
    logic [`GRAPH_ROM_ADDR_BITS-1:0] rom_addr;
    logic [7:0] rom_data;
    logic rom_valid;
    logic query_valid;
    logic query_ready;
    graph_pkg::node_name_t query_src;
    graph_pkg::node_name_t query_dst;
    logic result_valid;
    logic result_ready;
    logic [`GRAPH_COUNT_BITS-1:0] result_count;

    // expected counts are the number of distinct directed paths, counted by hand
    string test_names [NUM_TESTS] = '{
        "you_to_out", "aaa_to_out", "bbb_to_out", "ccc_to_out", "svr_to_ccc",
        "svr_to_out", "same_node", "absent_src", "absent_dst", "repeat_you_to_out"
    };
    graph_pkg::node_name_t test_srcs [NUM_TESTS] = '{
        "you", "aaa", "bbb", "ccc", "svr", "svr", "ccc", "qqq", "you", "you"
    };
    graph_pkg::node_name_t test_dsts [NUM_TESTS] = '{
        "out", "out", "out", "out", "ccc", "out", "ccc", "out", "zzz", "out"
    };
    logic [`GRAPH_COUNT_BITS-1:0] test_counts [NUM_TESTS] = '{
        64'd5, 64'd3, 64'd2, 64'd2, 64'd1, 64'd3, 64'd1, 64'd0, 64'd0, 64'd5
    };

    int checks;
    int mismatches;
    int other_errors;
    bit timed_out;
    logic [31:0] rng_state;

    netlist_rom rom_i (
        .addr(rom_addr),
        .data(rom_data),
        .valid(rom_valid)
    );

    graph_solver dut_i (
        .clk(clk),
        .rst(rst),
        .rom_addr(rom_addr),
        .rom_data(rom_data),
        .rom_valid(rom_valid),
        .query_valid(query_valid),
        .query_ready(query_ready),
        .query_src(query_src),
        .query_dst(query_dst),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .result_count(result_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic wait_query_ready(output int cycles);
        cycles = 0;
        while (!query_ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!query_ready) begin
            $display("Timeout: query_ready did not go high within %0d cycles", READY_TIMEOUT);
            other_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_result(input int idx);
        int cycles;
        cycles = 0;
        while (!result_valid && cycles < RESULT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!result_valid) begin
            $display("Timeout: no result for %s within %0d cycles",
                     test_names[idx], RESULT_TIMEOUT);
            other_errors++;
            timed_out = 1'b1;
        end
    endtask

    // the parser holds rom_addr at zero until the store clear is over,
    // and query_ready waits for the whole text
    task automatic check_build();
        int cycles;
        cycles = 0;
        while (rom_addr == '0 && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        if (rom_addr == '0) begin
            $display("Timeout: rom_addr did not leave zero within %0d cycles", READY_TIMEOUT);
            other_errors++;
            timed_out = 1'b1;
        end else if (cycles < `GRAPH_MAX_NODES) begin
            $display("rom_addr moved after %0d cycles, before the store was cleared",
                     cycles);
            other_errors++;
        end
        if (!timed_out) begin
            wait_query_ready(cycles);
        end
        if (!timed_out) begin
            checks++;
            if (rom_addr !== ROM_END) begin
                $display("Mismatch build_end_addr: expected %0d, actual %0d", ROM_END, rom_addr);
                mismatches++;
            end
        end
    endtask

    task automatic run_query(input int idx, input int stall);
        int cycles;
        logic [`GRAPH_COUNT_BITS-1:0] held;
        wait_query_ready(cycles);
        if (!timed_out) begin
            query_src = test_srcs[idx];
            query_dst = test_dsts[idx];
            query_valid = 1'b1;
            @(negedge clk);
            query_valid = 1'b0;
            checks++;
            if (query_ready) begin
                $display("query_ready stayed high after %s was accepted", test_names[idx]);
                other_errors++;
            end
            wait_result(idx);
        end
        if (!timed_out) begin
            held = result_count;
            checks++;
            if (held !== test_counts[idx]) begin
                $display("Mismatch %s: expected %0d, actual %0d",
                         test_names[idx], test_counts[idx], held);
                mismatches++;
            end
            // a competing query is offered while the result waits
            query_src = "svr";
            query_dst = "you";
            query_valid = 1'b1;
            for (int i = 0; i < stall; i++) begin
                @(negedge clk);
                checks++;
                if (!result_valid) begin
                    $display("result_valid dropped during back-pressure in %s",
                             test_names[idx]);
                    other_errors++;
                end
                if (result_count !== test_counts[idx]) begin
                    $display("Mismatch %s_hold: expected %0d, actual %0d",
                             test_names[idx], test_counts[idx], result_count);
                    mismatches++;
                end
                if (query_ready) begin
                    $display("query_ready went high while the %s result was pending",
                             test_names[idx]);
                    other_errors++;
                end
            end
            query_valid = 1'b0;
            result_ready = 1'b1;
            @(negedge clk);
            result_ready = 1'b0;
            checks++;
            if (result_valid) begin
                $display("result_valid stayed high after the %s result was taken",
                         test_names[idx]);
                other_errors++;
            end
        end
    endtask

    initial begin
        int stall;
        rst = 1'b1;
        query_valid = 1'b0;
        query_src = '0;
        query_dst = '0;
        result_ready = 1'b0;
        checks = 0;
        mismatches = 0;
        other_errors = 0;
        timed_out = 1'b0;
        rng_state = 32'd24;

        repeat (5) @(negedge clk);
        checks++;
        if (query_ready || result_valid || rom_addr !== '0) begin
            $display("outputs not idle during reset");
            other_errors++;
        end
        rst = 1'b0;

        check_build();
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            rng_state = xorshift32(rng_state);
            stall = int'(rng_state % 32'd6) + 1;
            run_query(t, stall);
        end

        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
source/graph_pkg.sv
source/graph_if.sv
source/name_table.sv
source/adjacency_store.sv
source/netlist_parser.sv
source/path_counter.sv
source/query_sequencer.sv
source/graph_solver.sv
verification/netlist_rom.sv
verification/tb_graph_solver.sv

// ==== Makefile ====
SIM := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP := tb_graph_solver
FILE_LIST := tb.f
BUILD_DIR := obj_dir
BIN := $(BUILD_DIR)/V$(TOP)

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(BUILD_DIR)
